//--- build.f
source/issue_pkg.sv
source/phys_regfile.sv
source/fu_fifo.sv
source/issue_stage.sv
source/issue_top.sv
sim/tb_clock.sv
sim/issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the issue stage testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module issue_tb -f build.f \
    -o issue_sim && ./obj_dir/issue_sim 2>&1 | tee sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/issue_input.txt
# wb x3 (en pr data), slot x3 (valid class op dest src1 src2), ready mask (hex, R for LFSR)
# class 0 alu, 1 ls, 2 mult, 3 br; all fields hex, one line per cycle
0 00 00000000 0 00 00000000 0 00 00000000  1 0 1 10 01 02  1 1 2 11 03 04  1 2 3 12 3f 00  ff
1 01 11111111 1 02 22222222 1 03 33333333  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  ff
1 00 deadbeef 1 04 44444444 1 05 55555555  1 0 4 13 01 02  1 2 5 14 03 00  1 3 6 15 04 05  ff
1 06 66666666 0 00 00000000 0 00 00000000  1 0 7 16 06 01  1 0 8 17 02 03  1 0 9 18 05 06  ff
0 00 00000000 0 00 00000000 0 00 00000000  1 1 a 19 01 02  1 0 b 1a 03 04  1 1 c 1b 05 06  ff
0 00 00000000 0 00 00000000 0 00 00000000  1 0 1 20 01 02  1 0 2 21 02 03  1 0 3 22 03 04  00
1 01 aaaaaaaa 1 02 bbbbbbbb 0 00 00000000  1 0 4 23 04 05  1 0 5 24 05 06  1 0 6 25 06 01  00
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  05
1 03 cccccccc 0 00 00000000 0 00 00000000  1 0 7 26 01 02  0 0 0 00 00 00  0 0 0 00 00 00  02
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  06
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  07
0 00 00000000 0 00 00000000 0 00 00000000  1 1 1 30 01 03  1 2 2 31 02 03  1 1 3 32 06 05  10
0 00 00000000 0 00 00000000 0 00 00000000  1 2 4 33 04 05  1 2 5 34 01 01  0 0 0 00 00 00  50
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  28
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  ff
0 00 00000000 0 00 00000000 0 00 00000000  1 3 1 40 01 02  1 3 2 41 03 04  1 3 3 42 05 06  7f
0 00 00000000 0 00 00000000 0 00 00000000  1 3 4 43 02 01  1 3 5 44 04 03  1 3 6 45 06 05  7f
1 05 12345678 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  00
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  80
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  80
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  80
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  80
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  80
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  80
1 07 0badf00d 0 00 00000000 0 00 00000000  1 0 1 50 07 01  1 1 2 51 02 07  1 2 3 52 03 04  R
0 00 00000000 0 00 00000000 0 00 00000000  1 3 4 53 05 06  1 0 5 54 01 02  1 1 6 55 03 04  R
1 08 fedcba98 0 00 00000000 0 00 00000000  1 2 7 56 08 07  1 0 8 57 06 05  1 0 9 58 04 03  R
0 00 00000000 0 00 00000000 0 00 00000000  1 0 a 59 02 02  1 1 b 5a 01 03  1 2 c 5b 07 08  R
0 00 00000000 0 00 00000000 0 00 00000000  1 0 d 5c 05 05  1 3 e 5d 06 06  1 1 f 5e 01 01  R
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  R
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  R
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  ff
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  ff
0 00 00000000 0 00 00000000 0 00 00000000  0 0 0 00 00 00  0 0 0 00 00 00  0 0 0 00 00 00  ff

//--- sim/issue_tb.sv
`default_nettype none

module issue_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [3:0]  op;
        logic [5:0]  dest;
        logic [31:0] opa;
        logic [31:0] opb;
    } exp_word_t;

    logic                       clock;
    logic                       arst_n;
    logic [2:0]                 rs_valid;
    issue_pkg::fu_class_e [2:0] rs_class;
    logic [2:0][3:0]            rs_op;
    logic [2:0][5:0]            rs_dest_pr;
    logic [2:0][5:0]            rs_src1_pr;
    logic [2:0][5:0]            rs_src2_pr;
    logic [2:0]                 wb_en;
    logic [2:0][5:0]            wb_pr;
    logic [2:0][31:0]           wb_data;
    logic [7:0]                 fu_ready;
    logic [7:0]                 fu_valid;
    logic [7:0][3:0]            fu_op;
    logic [7:0][5:0]            fu_dest_pr;
    logic [7:0][31:0]           fu_opa;
    logic [7:0][31:0]           fu_opb;
    logic [3:0]                 fifo_stall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [31:0] model_regs [64];
    exp_word_t   class_q [4][$];           // Expected FIFO contents, oldest first
    int          taken_n [4];
    int          port_base [4] = '{0, 3, 5, 7};
    int          port_count [4] = '{3, 2, 2, 1};
    string       lines [$];
    string       fields [$];
    logic [31:0] lfsr = 32'he77c_1d8d;
    bit          loaded = 1'b0;
    int          errors = 0;
    int          checks = 0;

    tb_clock clk_gen (.clock(clock));

    issue_top dut (
        .clock      (clock),
        .arst_n     (arst_n),
        .rs_valid   (rs_valid),
        .rs_class   (rs_class),
        .rs_op      (rs_op),
        .rs_dest_pr (rs_dest_pr),
        .rs_src1_pr (rs_src1_pr),
        .rs_src2_pr (rs_src2_pr),
        .wb_en      (wb_en),
        .wb_pr      (wb_pr),
        .wb_data    (wb_data),
        .fu_ready   (fu_ready),
        .fu_valid   (fu_valid),
        .fu_op      (fu_op),
        .fu_dest_pr (fu_dest_pr),
        .fu_opa     (fu_opa),
        .fu_opb     (fu_opb),
        .fifo_stall (fifo_stall)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] random_mask();
        logic [7:0] m;
        for (int b = 0; b < 8; b++) begin
            m[b] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        return m;
    endfunction

    function automatic bit class_stalled(input int c);
        return (8 - class_q[c].size()) < 3;
    endfunction

    // Register 0 reads zero, same-cycle writebacks win over the array
    function automatic logic [31:0] read_operand(input logic [5:0] idx);
        logic [31:0] val;
        if (idx == 6'd0) begin
            return 32'd0;
        end
        val = model_regs[idx];
        for (int p = 0; p < 3; p++) begin
            if (wb_en[p] && (wb_pr[p] == idx)) begin
                val = wb_data[p];
            end
        end
        return val;
    endfunction

    function automatic void split_fields(input string text);
        string tok;
        tok = "";
        fields.delete();
        for (int i = 0; i < text.len(); i++) begin
            if (text[i] == " " || text[i] == "\t" || text[i] == "\n" || text[i] == "\r") begin
                if (tok.len() > 0) begin
                    fields.push_back(tok);
                end
                tok = "";
            end else begin
                tok = {tok, text.substr(i, i)};
            end
        end
        if (tok.len() > 0) begin
            fields.push_back(tok);
        end
    endfunction

    task automatic load_input();
        int    fd;
        string text;
        fd = $fopen("sim/issue_input.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/issue_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text[0] != "#") begin
                lines.push_back(text);
            end
        end
        $fclose(fd);
    endtask

    // Drives one cycle of stimulus, holding back slots of a stalled class
    task automatic apply_line(input string text);
        int b;
        rs_valid = '0;
        wb_en    = '0;
        split_fields(text);
        if (fields.size() != 28) begin
            $display("input line has %0d fields instead of 28: %s", fields.size(), text);
            errors++;
            return;
        end
        for (int p = 0; p < 3; p++) begin
            wb_en[p]   = fields[3 * p].atohex() != 0;
            wb_pr[p]   = 6'(fields[3 * p + 1].atohex());
            wb_data[p] = 32'(fields[3 * p + 2].atohex());
        end
        for (int s = 0; s < 3; s++) begin
            b             = 9 + 6 * s;
            rs_class[s]   = issue_pkg::fu_class_e'(2'(fields[b + 1].atohex()));
            rs_valid[s]   = (fields[b].atohex() != 0) && !class_stalled(int'(rs_class[s]));
            rs_op[s]      = 4'(fields[b + 2].atohex());
            rs_dest_pr[s] = 6'(fields[b + 3].atohex());
            rs_src1_pr[s] = 6'(fields[b + 4].atohex());
            rs_src2_pr[s] = 6'(fields[b + 5].atohex());
        end
        fu_ready = (fields[27] == "R") ? random_mask() : 8'(fields[27].atohex());
    endtask

    task automatic compare(input int cyc, input string name, input int idx,
                           input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH line %0d %s[%0d] expected %h actual %h", cyc, name, idx, exp, act);
            errors++;
        end
    endtask

    task automatic check_outputs(input int cyc);
        exp_word_t w;
        logic      ev;
        int        u;
        int        taken;
        for (int c = 0; c < 4; c++) begin
            taken = 0;
            for (int k = 0; k < port_count[c]; k++) begin
                u  = port_base[c] + k;
                w  = '0;
                ev = 1'b0;
                if (fu_ready[u] && (taken < class_q[c].size())) begin
                    w  = class_q[c][taken];
                    ev = 1'b1;
                    taken++;
                end
                compare(cyc, "fu_valid", u, 32'(ev), 32'(fu_valid[u]));
                compare(cyc, "fu_op", u, 32'(w.op), 32'(fu_op[u]));
                compare(cyc, "fu_dest_pr", u, 32'(w.dest), 32'(fu_dest_pr[u]));
                compare(cyc, "fu_opa", u, w.opa, fu_opa[u]);
                compare(cyc, "fu_opb", u, w.opb, fu_opb[u]);
            end
            taken_n[c] = taken;
            compare(cyc, "fifo_stall", c, 32'(class_stalled(c)), 32'(fifo_stall[c]));
        end
    endtask

    // Clock edge: pop issued entries, append new words, then write registers
    task automatic update_model();
        exp_word_t w;
        int        c;
        for (int k = 0; k < 4; k++) begin
            repeat (taken_n[k]) void'(class_q[k].pop_front());
        end
        for (int s = 0; s < 3; s++) begin
            if (rs_valid[s]) begin
                c      = int'(rs_class[s]);
                w.op   = rs_op[s];
                w.dest = rs_dest_pr[s];
                w.opa  = read_operand(rs_src1_pr[s]);
                w.opb  = read_operand(rs_src2_pr[s]);
                if (class_q[c].size() < 8) begin
                    class_q[c].push_back(w);
                end
            end
        end
        for (int p = 0; p < 3; p++) begin
            if (wb_en[p] && (wb_pr[p] != 6'd0)) begin
                model_regs[wb_pr[p]] = wb_data[p];
            end
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        rs_valid   = '0;
        rs_op      = '0;
        rs_dest_pr = '0;
        rs_src1_pr = '0;
        rs_src2_pr = '0;
        wb_en      = '0;
        wb_pr      = '0;
        wb_data    = '0;
        fu_ready   = '0;
        for (int s = 0; s < 3; s++) begin
            rs_class[s] = issue_pkg::FU_ALU;
        end
        for (int r = 0; r < 64; r++) begin
            model_regs[r] = '0;
        end
        load_input();
        loaded = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        foreach (lines[n]) begin
            @(negedge clock);
            apply_line(lines[n]);
            #45;                             // Just before the rising edge
            check_outputs(n + 1);
            update_model();
        end
        @(negedge clock);
        $display("errors: %0d  checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the number of stimulus lines
    initial begin
        wait (loaded);
        #((lines.size() + 10) * 100);
        $display("timeout after %0d stimulus lines, run did not finish", lines.size());
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clock
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period, rising edges at 50 ns + n * 100 ns
    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

endmodule

`default_nettype wire

//--- source/fu_fifo.sv
`default_nettype none

module fu_fifo #(
    parameter int num_rd = 3
) (
    input  logic                                                 clock,
    input  logic                                                 arst_n,
    input  logic [issue_pkg::issue_width-1:0]                    wr_en,
    input  issue_pkg::issue_word_t [issue_pkg::issue_width-1:0]  wr_word,
    input  logic [num_rd-1:0]                                    rd_ready,
    output logic [num_rd-1:0]                                    rd_valid,
    output issue_pkg::issue_word_t [num_rd-1:0]                  rd_word,
    output logic                                                 almost_full
);

    issue_pkg::issue_word_t           mem [issue_pkg::fifo_depth];
    logic [issue_pkg::fifo_ptr_w-1:0] head;
    logic [issue_pkg::fifo_ptr_w-1:0] tail;
    logic [issue_pkg::fifo_cnt_w-1:0] count;

    logic [issue_pkg::fifo_cnt_w-1:0] n_rd;           // Entries leaving this cycle
    logic [issue_pkg::fifo_cnt_w-1:0] n_wr;           // Entries arriving this cycle
    logic [issue_pkg::fifo_cnt_w-1:0] occ_after_rd;
    logic [issue_pkg::issue_width-1:0] wr_accept;
    logic [issue_pkg::issue_width-1:0] wr_drop;
    logic [issue_pkg::fifo_ptr_w-1:0] wr_ptr [issue_pkg::issue_width];

    // Circular pointer advance, wraps for any depth
    function automatic logic [issue_pkg::fifo_ptr_w-1:0] ptr_add(
        input logic [issue_pkg::fifo_ptr_w-1:0] ptr,
        input logic [issue_pkg::fifo_cnt_w-1:0] n
    );
        logic [issue_pkg::fifo_cnt_w:0] sum;
        sum = ptr + n;
        if (sum >= issue_pkg::fifo_depth) begin
            sum = sum - (issue_pkg::fifo_cnt_w + 1)'(issue_pkg::fifo_depth);
        end
        return sum[issue_pkg::fifo_ptr_w-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side: oldest entries to the ready ports, lowest port first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        n_rd = '0;
        for (int p = 0; p < num_rd; p++) begin
            rd_valid[p] = 1'b0;
            rd_word[p]  = '0;
            if (rd_ready[p] && (n_rd < count)) begin
                rd_valid[p] = 1'b1;
                rd_word[p]  = mem[ptr_add(head, n_rd)];
                n_rd        = n_rd + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side: enabled slots compacted behind the tail
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        occ_after_rd = count - n_rd;
        n_wr         = '0;
        for (int s = 0; s < issue_pkg::issue_width; s++) begin
            wr_accept[s] = 1'b0;
            wr_drop[s]   = 1'b0;
            wr_ptr[s]    = ptr_add(tail, n_wr);
            if (wr_en[s]) begin
                if ((occ_after_rd + n_wr) < issue_pkg::fifo_depth) begin
                    wr_accept[s] = 1'b1;
                    n_wr         = n_wr + 1'b1;
                end else begin
                    wr_drop[s] = 1'b1;    // No room left, word is lost
                end
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= ptr_add(head, n_rd);
            tail  <= ptr_add(tail, n_wr);
            count <= occ_after_rd + n_wr;
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < issue_pkg::issue_width; s++) begin
            if (wr_accept[s]) begin
                mem[wr_ptr[s]] <= wr_word[s];
            end
        end
    end

    // Room for a full dispatch group must exist at the start of the cycle
    assign almost_full = (issue_pkg::fifo_depth - count) < issue_pkg::issue_width;

    a_count_bound: assert property (
        @(posedge clock) disable iff (!arst_n) count <= issue_pkg::fifo_depth)
        else $error("fu_fifo: occupancy above depth");

    // Upstream honours almost_full, so nothing should ever be dropped
    a_no_drop: assert property (@(posedge clock) disable iff (!arst_n) wr_drop == '0)
        else $error("fu_fifo: write into a full FIFO");

endmodule

`default_nettype wire

//--- source/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core widths and counts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen_w      = 32;
    localparam int pr_w        = 6;
    localparam int pr_count    = 64;
    localparam int op_w        = 4;
    localparam int issue_width = 3;    // Dispatch slots and writeback ports
    localparam int class_count = 4;

    localparam int fifo_depth  = 8;
    localparam int fifo_ptr_w  = $clog2(fifo_depth);
    localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);

    // Unit port map
    localparam int fu_count    = 8;
    localparam int alu_base    = 0;
    localparam int alu_count   = 3;
    localparam int ls_base     = 3;
    localparam int ls_count    = 2;
    localparam int mult_base   = 5;
    localparam int mult_count  = 2;
    localparam int br_base     = 7;
    localparam int br_count    = 1;

    typedef logic [xlen_w-1:0] word_t;
    typedef logic [pr_w-1:0]   preg_t;
    typedef logic [op_w-1:0]   op_t;

    // Issue word, MSB first: op, dest, opa, opb
    localparam int iw_opb_lsb  = 0;
    localparam int iw_opa_lsb  = iw_opb_lsb + xlen_w;
    localparam int iw_dest_lsb = iw_opa_lsb + xlen_w;
    localparam int iw_op_lsb   = iw_dest_lsb + pr_w;
    localparam int iw_w        = iw_op_lsb + op_w;

    typedef logic [iw_w-1:0] issue_word_t;

    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_LS   = 2'd1,
        FU_MULT = 2'd2,
        FU_BR   = 2'd3
    } fu_class_e;

endpackage

`default_nettype wire

//--- source/issue_stage.sv
`default_nettype none

module issue_stage (
    input  logic                                                clock,
    input  logic                                                arst_n,
    input  logic [issue_pkg::issue_width-1:0]                   rs_valid,
    input  issue_pkg::fu_class_e [issue_pkg::issue_width-1:0]   rs_class,
    input  issue_pkg::op_t [issue_pkg::issue_width-1:0]         rs_op,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rs_dest_pr,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rs_src1_pr,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rs_src2_pr,
    output issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rda_idx,
    output issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rdb_idx,
    input  issue_pkg::word_t [issue_pkg::issue_width-1:0]       rda_data,
    input  issue_pkg::word_t [issue_pkg::issue_width-1:0]       rdb_data,
    input  logic [issue_pkg::fu_count-1:0]                      fu_ready,
    output logic [issue_pkg::fu_count-1:0]                      fu_valid,
    output issue_pkg::op_t [issue_pkg::fu_count-1:0]            fu_op,
    output issue_pkg::preg_t [issue_pkg::fu_count-1:0]          fu_dest_pr,
    output issue_pkg::word_t [issue_pkg::fu_count-1:0]          fu_opa,
    output issue_pkg::word_t [issue_pkg::fu_count-1:0]          fu_opb,
    output logic [issue_pkg::class_count-1:0]                   fifo_stall
);

    issue_pkg::issue_word_t [issue_pkg::issue_width-1:0] slot_word;
    issue_pkg::issue_word_t [issue_pkg::fu_count-1:0]    unit_word;
    logic [issue_pkg::issue_width-1:0]                   cls_wr_en [issue_pkg::class_count];
    logic                                                stalled_dispatch;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand read and word packing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int s = 0; s < issue_pkg::issue_width; s++) begin
            rda_idx[s]   = rs_src1_pr[s];
            rdb_idx[s]   = rs_src2_pr[s];
            slot_word[s] = {rs_op[s], rs_dest_pr[s], rda_data[s], rdb_data[s]};
        end
    end

    // One write enable vector per class FIFO
    always_comb begin
        for (int c = 0; c < issue_pkg::class_count; c++) begin
            for (int s = 0; s < issue_pkg::issue_width; s++) begin
                cls_wr_en[c][s] = rs_valid[s] && (rs_class[s] == issue_pkg::fu_class_e'(c));
            end
        end
    end

    fu_fifo #(.num_rd(issue_pkg::alu_count)) alu_fifo (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr_en       (cls_wr_en[issue_pkg::FU_ALU]),
        .wr_word     (slot_word),
        .rd_ready    (fu_ready[issue_pkg::alu_base +: issue_pkg::alu_count]),
        .rd_valid    (fu_valid[issue_pkg::alu_base +: issue_pkg::alu_count]),
        .rd_word     (unit_word[issue_pkg::alu_base +: issue_pkg::alu_count]),
        .almost_full (fifo_stall[issue_pkg::FU_ALU])
    );

    fu_fifo #(.num_rd(issue_pkg::ls_count)) ls_fifo (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr_en       (cls_wr_en[issue_pkg::FU_LS]),
        .wr_word     (slot_word),
        .rd_ready    (fu_ready[issue_pkg::ls_base +: issue_pkg::ls_count]),
        .rd_valid    (fu_valid[issue_pkg::ls_base +: issue_pkg::ls_count]),
        .rd_word     (unit_word[issue_pkg::ls_base +: issue_pkg::ls_count]),
        .almost_full (fifo_stall[issue_pkg::FU_LS])
    );

    fu_fifo #(.num_rd(issue_pkg::mult_count)) mult_fifo (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr_en       (cls_wr_en[issue_pkg::FU_MULT]),
        .wr_word     (slot_word),
        .rd_ready    (fu_ready[issue_pkg::mult_base +: issue_pkg::mult_count]),
        .rd_valid    (fu_valid[issue_pkg::mult_base +: issue_pkg::mult_count]),
        .rd_word     (unit_word[issue_pkg::mult_base +: issue_pkg::mult_count]),
        .almost_full (fifo_stall[issue_pkg::FU_MULT])
    );

    fu_fifo #(.num_rd(issue_pkg::br_count)) br_fifo (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr_en       (cls_wr_en[issue_pkg::FU_BR]),
        .wr_word     (slot_word),
        .rd_ready    (fu_ready[issue_pkg::br_base +: issue_pkg::br_count]),
        .rd_valid    (fu_valid[issue_pkg::br_base +: issue_pkg::br_count]),
        .rd_word     (unit_word[issue_pkg::br_base +: issue_pkg::br_count]),
        .almost_full (fifo_stall[issue_pkg::FU_BR])
    );

    // Unpack per unit port, idle ports carry an all-zero word
    always_comb begin
        for (int u = 0; u < issue_pkg::fu_count; u++) begin
            fu_op[u]      = unit_word[u][issue_pkg::iw_op_lsb +: issue_pkg::op_w];
            fu_dest_pr[u] = unit_word[u][issue_pkg::iw_dest_lsb +: issue_pkg::pr_w];
            fu_opa[u]     = unit_word[u][issue_pkg::iw_opa_lsb +: issue_pkg::xlen_w];
            fu_opb[u]     = unit_word[u][issue_pkg::iw_opb_lsb +: issue_pkg::xlen_w];
        end
    end

    always_comb begin
        stalled_dispatch = 1'b0;
        for (int c = 0; c < issue_pkg::class_count; c++) begin
            if (fifo_stall[c] && (|cls_wr_en[c])) begin
                stalled_dispatch = 1'b1;
            end
        end
    end

    // Reservation stations must hold back any class that reported stall
    a_stall_obeyed: assert property (
        @(posedge clock) disable iff (!arst_n) !stalled_dispatch)
        else $error("issue_stage: dispatch to a stalled class");

endmodule

`default_nettype wire

//--- source/issue_top.sv
`default_nettype none

module issue_top (
    input  logic                                                clock,
    input  logic                                                arst_n,
    input  logic [issue_pkg::issue_width-1:0]                   rs_valid,
    input  issue_pkg::fu_class_e [issue_pkg::issue_width-1:0]   rs_class,
    input  issue_pkg::op_t [issue_pkg::issue_width-1:0]         rs_op,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rs_dest_pr,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rs_src1_pr,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]       rs_src2_pr,
    input  logic [issue_pkg::issue_width-1:0]                   wb_en,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]       wb_pr,
    input  issue_pkg::word_t [issue_pkg::issue_width-1:0]       wb_data,
    input  logic [issue_pkg::fu_count-1:0]                      fu_ready,
    output logic [issue_pkg::fu_count-1:0]                      fu_valid,
    output issue_pkg::op_t [issue_pkg::fu_count-1:0]            fu_op,
    output issue_pkg::preg_t [issue_pkg::fu_count-1:0]          fu_dest_pr,
    output issue_pkg::word_t [issue_pkg::fu_count-1:0]          fu_opa,
    output issue_pkg::word_t [issue_pkg::fu_count-1:0]          fu_opb,
    output logic [issue_pkg::class_count-1:0]                   fifo_stall
);

    issue_pkg::preg_t [issue_pkg::issue_width-1:0] rda_idx;
    issue_pkg::preg_t [issue_pkg::issue_width-1:0] rdb_idx;
    issue_pkg::word_t [issue_pkg::issue_width-1:0] rda_data;    // Operand A per slot
    issue_pkg::word_t [issue_pkg::issue_width-1:0] rdb_data;    // Operand B per slot

    phys_regfile prf (
        .clock    (clock),
        .arst_n   (arst_n),
        .wb_en    (wb_en),
        .wb_pr    (wb_pr),
        .wb_data  (wb_data),
        .rda_idx  (rda_idx),
        .rdb_idx  (rdb_idx),
        .rda_data (rda_data),
        .rdb_data (rdb_data)
    );

    issue_stage issue (
        .clock      (clock),
        .arst_n     (arst_n),
        .rs_valid   (rs_valid),
        .rs_class   (rs_class),
        .rs_op      (rs_op),
        .rs_dest_pr (rs_dest_pr),
        .rs_src1_pr (rs_src1_pr),
        .rs_src2_pr (rs_src2_pr),
        .rda_idx    (rda_idx),
        .rdb_idx    (rdb_idx),
        .rda_data   (rda_data),
        .rdb_data   (rdb_data),
        .fu_ready   (fu_ready),
        .fu_valid   (fu_valid),
        .fu_op      (fu_op),
        .fu_dest_pr (fu_dest_pr),
        .fu_opa     (fu_opa),
        .fu_opb     (fu_opb),
        .fifo_stall (fifo_stall)
    );

endmodule

`default_nettype wire

//--- source/phys_regfile.sv
`default_nettype none

module phys_regfile (
    input  logic                                           clock,
    input  logic                                           arst_n,
    input  logic [issue_pkg::issue_width-1:0]              wb_en,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]  wb_pr,
    input  issue_pkg::word_t [issue_pkg::issue_width-1:0]  wb_data,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]  rda_idx,
    input  issue_pkg::preg_t [issue_pkg::issue_width-1:0]  rdb_idx,
    output issue_pkg::word_t [issue_pkg::issue_width-1:0]  rda_data,
    output issue_pkg::word_t [issue_pkg::issue_width-1:0]  rdb_data
);

    issue_pkg::word_t regs [issue_pkg::pr_count];
    logic             wb_collide;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports with same-cycle writeback bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int s = 0; s < issue_pkg::issue_width; s++) begin
            rda_data[s] = regs[rda_idx[s]];
            rdb_data[s] = regs[rdb_idx[s]];
            for (int p = 0; p < issue_pkg::issue_width; p++) begin
                if (wb_en[p] && (wb_pr[p] == rda_idx[s])) begin
                    rda_data[s] = wb_data[p];
                end
                if (wb_en[p] && (wb_pr[p] == rdb_idx[s])) begin
                    rdb_data[s] = wb_data[p];
                end
            end
            // p0 is the zero register
            if (rda_idx[s] == '0) begin
                rda_data[s] = '0;
            end
            if (rdb_idx[s] == '0) begin
                rdb_data[s] = '0;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < issue_pkg::pr_count; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < issue_pkg::issue_width; p++) begin
                if (wb_en[p] && (wb_pr[p] != '0)) begin
                    regs[wb_pr[p]] <= wb_data[p];
                end
            end
        end
    end

    always_comb begin
        wb_collide = 1'b0;
        for (int p = 0; p < issue_pkg::issue_width; p++) begin
            for (int q = p + 1; q < issue_pkg::issue_width; q++) begin
                if (wb_en[p] && wb_en[q] && (wb_pr[p] == wb_pr[q])) begin
                    wb_collide = 1'b1;
                end
            end
        end
    end

    // Rename never hands one register to two producers finishing together
    a_wb_unique: assert property (@(posedge clock) disable iff (!arst_n) !wb_collide)
        else $error("phys_regfile: two writebacks target the same register");

endmodule

`default_nettype wire
